// File: hart_pkg.sv
package hart_pkg;

    localparam int NUM_HARTS  = 4;
    localparam int HART_IDX_W = $clog2(NUM_HARTS);

    typedef logic [NUM_HARTS-1:0]  hstate_t;   // one bit per hart, bit 3 is hart 3
    typedef logic [HART_IDX_W-1:0] hidx_t;
    typedef logic [15:0]           instr_t;    // class in [15:14], rest unused here
    typedef logic [7:0]            pc_t;

    typedef enum logic [1:0] {
        OP_ALU    = 2'b00,
        OP_LOAD   = 2'b01,
        OP_BRANCH = 2'b10,
        OP_NOP    = 2'b11
    } op_class_t;

    // isolate lowest set bit, zero stays zero
    function automatic hstate_t lowest_hart(hstate_t mask);
        return mask & (~mask + hstate_t'(1));
    endfunction

    // index of lowest set bit, 0 for an empty mask
    function automatic hidx_t hart_idx(hstate_t mask);
        hidx_t idx;
        idx = '0;
        for (int h = NUM_HARTS - 1; h >= 0; h--) begin
            if (mask[h]) idx = hidx_t'(h);
        end
        return idx;
    endfunction

    function automatic op_class_t instr_class(instr_t instr);
        return op_class_t'(instr[15:14]);
    endfunction

endpackage

// File: hart_stage_if.sv
`timescale 1ns/1ps

// one pipeline stage between fetch and decode
interface hart_stage_if;
    import hart_pkg::*;

    hstate_t hstate;   // harts carried by this stage
    logic    valid;
    pc_t     pc;       // pc of lowest hart in hstate
    instr_t  instr;

    // producer side, registers the stage
    modport src (
        output hstate,
        output valid,
        output pc,
        output instr
    );

    // consumer side
    modport dst (
        input hstate,
        input valid,
        input pc,
        input instr
    );

endinterface

// File: hart_state_unit.sv
`timescale 1ns/1ps

module hart_state_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              set_hart,
    input  hart_pkg::hstate_t set_hstate,
    input  logic              set_hart_val,   // 1 activates, 0 idles
    output hart_pkg::hstate_t acti_hstate,
    output hart_pkg::hstate_t prim_hstate,
    output logic              prim_leave
);
    import hart_pkg::*;

    hstate_t acti_next;
    hstate_t prim_next;

    always_comb begin
        acti_next = acti_hstate;
        if (set_hart) begin
            if (set_hart_val) begin
                acti_next = acti_hstate | set_hstate;
            end else begin
                acti_next = acti_hstate & ~set_hstate;
            end
        end
    end

    // current primary is being idled this cycle
    assign prim_leave = set_hart && !set_hart_val && ((set_hstate & prim_hstate) != '0);

    always_comb begin
        prim_next = prim_hstate;
        // hand over to lowest remaining, or adopt first activated hart
        if (prim_leave || (prim_hstate == '0)) begin
            prim_next = lowest_hart(acti_next);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acti_hstate <= '0;
            prim_hstate <= '0;
        end else begin
            acti_hstate <= acti_next;
            prim_hstate <= prim_next;
        end
    end

    // at most one primary at any time
    a_prim_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(prim_hstate));

    a_prim_in_acti: assert property (@(posedge clk) disable iff (rst)
        (prim_hstate & ~acti_hstate) == '0);

endmodule

// File: hart_switch.sv
`timescale 1ns/1ps

module hart_switch (
    input  logic              clk,
    input  logic              rst,
    input  logic              prim_leave,
    input  hart_pkg::hstate_t acti_hstate,
    input  hart_pkg::hstate_t prim_hstate,
    input  logic              is_branch,     // decode stage feedback
    input  logic              is_load,
    input  hart_pkg::hstate_t id_hstate,
    output hart_pkg::hstate_t issue_hstate
);
    import hart_pkg::*;

    hstate_t minor_hstate;
    hstate_t one_hot_hstate;
    hstate_t last_issue;       // mask issued in previous cycle
    hstate_t shifted_issue;
    logic    prim_hit;         // decode holds the primary hart alone
    logic    three_active;
    logic    one_minor;
    logic    issue_minor;
    logic    issue_twice;

    // lowest minor hart as a one-hot mask
    function automatic hstate_t pick_minor(hstate_t minor);
        return lowest_hart(minor);
    endfunction

    // rotate right by one, an empty or exhausted mask restarts at hart 3
    function automatic hstate_t rotate_right(hstate_t mask);
        hstate_t shifted;
        shifted = mask >> 1;
        if (shifted == '0) begin
            shifted = hstate_t'(1) << (NUM_HARTS - 1);
        end
        return shifted;
    endfunction

    assign minor_hstate   = acti_hstate & ~prim_hstate;
    assign one_hot_hstate = pick_minor(minor_hstate);
    assign shifted_issue  = rotate_right(last_issue);

    assign prim_hit     = (id_hstate == prim_hstate) && (prim_hstate != '0);
    assign three_active = ($countones(acti_hstate) == 3);
    assign one_minor    = $onehot(minor_hstate);

    always_comb begin
        if (prim_leave) begin
            issue_hstate = one_hot_hstate;
        end else if (acti_hstate == '1) begin
            issue_hstate = shifted_issue;     // full interleave
        end else if (minor_hstate == '0) begin
            issue_hstate = prim_hstate;
        end else if ((is_branch || is_load) && prim_hit) begin
            issue_hstate = one_hot_hstate;
        end else if (issue_minor) begin
            if (issue_twice) begin
                issue_hstate = minor_hstate;
            end else begin
                issue_hstate = ~last_issue & minor_hstate;
            end
        end else begin
            issue_hstate = prim_hstate;
        end
    end

    // minor slots after a primary load, or a branch with three harts up
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_minor <= 1'b0;
            issue_twice <= 1'b0;
        end else begin
            issue_minor <= prim_hit && (is_load || (is_branch && three_active));
            issue_twice <= is_load && one_minor;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_issue <= '0;
        end else begin
            last_issue <= issue_hstate;
        end
    end

    // never issue a hart the state unit has not activated
    a_issue_in_acti: assert property (@(posedge clk) disable iff (rst)
        (issue_hstate & ~acti_hstate) == '0);

    // rotation keeps exactly one hart per cycle
    a_rotate_onehot: assert property (@(posedge clk) disable iff (rst)
        (acti_hstate == '1) && !prim_leave |-> $onehot(issue_hstate));

endmodule

// File: hart_fetch.sv
`timescale 1ns/1ps

module hart_fetch #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  hart_pkg::hstate_t             issue_hstate,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  hart_pkg::instr_t              imem_data,
    hart_stage_if.src                     fetch
);
    import hart_pkg::*;

    localparam int AW  = $clog2(IMEM_DEPTH);
    localparam int PCW = AW - HART_IDX_W;    // pc bits used per hart region

    instr_t          imem [IMEM_DEPTH];
    pc_t             pc_q [NUM_HARTS];
    hidx_t           rd_hart;
    logic [AW-1:0]   rd_addr;

    // hart index selects the memory quarter
    always_comb begin
        rd_hart = hart_idx(issue_hstate);
        rd_addr = {rd_hart, pc_q[rd_hart][PCW-1:0]};
    end

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;   // preload port
        end
    end

    // every issued hart steps its own pc
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int h = 0; h < NUM_HARTS; h++) begin
                pc_q[h] <= '0;
            end
        end else begin
            for (int h = 0; h < NUM_HARTS; h++) begin
                if (issue_hstate[h]) begin
                    pc_q[h] <= pc_q[h] + pc_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch.hstate <= '0;
            fetch.valid  <= 1'b0;
        end else begin
            fetch.hstate <= issue_hstate;
            fetch.valid  <= (issue_hstate != '0);
        end
    end

    // payload of the stage
    always_ff @(posedge clk) begin
        fetch.pc    <= pc_q[rd_hart];
        fetch.instr <= imem[rd_addr];
    end

endmodule

// File: hart_decode.sv
`timescale 1ns/1ps

module hart_decode (
    input  logic              clk,
    input  logic              rst,
    hart_stage_if.dst         fetch,
    hart_stage_if.src         dec,         // registered decode stage
    output logic              is_load,
    output logic              is_branch,
    output hart_pkg::hstate_t id_hstate,
    output hart_pkg::pc_t     id_pc
);
    import hart_pkg::*;

    op_class_t op_class;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.hstate <= '0;
            dec.valid  <= 1'b0;
        end else begin
            dec.hstate <= fetch.hstate;
            dec.valid  <= fetch.valid;
        end
    end

    always_ff @(posedge clk) begin
        dec.pc    <= fetch.pc;
        dec.instr <= fetch.instr;
    end

    assign op_class = instr_class(dec.instr);

    // bubbles never report a load or branch
    assign is_load   = dec.valid && (op_class == OP_LOAD);
    assign is_branch = dec.valid && (op_class == OP_BRANCH);

    assign id_hstate = dec.hstate;
    assign id_pc     = dec.pc;

endmodule

// File: hart_core_top.sv
`timescale 1ns/1ps

module hart_core_top #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          set_hart,
    input  hart_pkg::hstate_t             set_hstate,
    input  logic                          set_hart_val,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  hart_pkg::instr_t              imem_data,
    output hart_pkg::hstate_t             issue_hstate,
    output hart_pkg::hstate_t             id_hstate,
    output hart_pkg::pc_t                 id_pc,
    output logic                          is_load,
    output logic                          is_branch,
    output hart_pkg::hstate_t             acti_hstate,
    output hart_pkg::hstate_t             prim_hstate
);
    logic prim_leave;

    hart_stage_if fetch_if ();
    hart_stage_if dec_if ();

    hart_state_unit u_state (
        .clk          (clk),
        .rst          (rst),
        .set_hart     (set_hart),
        .set_hstate   (set_hstate),
        .set_hart_val (set_hart_val),
        .acti_hstate  (acti_hstate),
        .prim_hstate  (prim_hstate),
        .prim_leave   (prim_leave)
    );

    hart_switch u_switch (
        .clk          (clk),
        .rst          (rst),
        .prim_leave   (prim_leave),
        .acti_hstate  (acti_hstate),
        .prim_hstate  (prim_hstate),
        .is_branch    (is_branch),
        .is_load      (is_load),
        .id_hstate    (id_hstate),
        .issue_hstate (issue_hstate)
    );

    hart_fetch #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch (
        .clk          (clk),
        .rst          (rst),
        .issue_hstate (issue_hstate),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .fetch        (fetch_if.src)
    );

    hart_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .fetch     (fetch_if.dst),
        .dec       (dec_if.src),
        .is_load   (is_load),
        .is_branch (is_branch),
        .id_hstate (id_hstate),
        .id_pc     (id_pc)
    );

endmodule

// File: tb_hart_core.sv
`timescale 1ns/1ps

module tb_hart_core;
    import hart_pkg::*;

    localparam int IMEM_DEPTH   = 256;
    localparam int AW           = $clog2(IMEM_DEPTH);
    localparam int PC_BITS      = AW - HART_IDX_W;   // pc bits inside one hart quarter
    localparam int RESET_CYCLES = 5;
    localparam int NUM_STEPS    = 11;

    // set command and run length with the masks expected after the step
    typedef struct packed {
        logic       do_set;
        hstate_t    hstate;
        logic       val;
        logic [7:0] cycles;
        hstate_t    exp_acti;
        hstate_t    exp_prim;
        logic       need_fb;   // primary load or branch must reach decode
    } step_t;

    localparam step_t STEPS [NUM_STEPS] = '{
        '{1'b1, 4'b0100, 1'b1, 8'd12, 4'b0100, 4'b0100, 1'b0},
        '{1'b1, 4'b0001, 1'b1, 8'd40, 4'b0101, 4'b0100, 1'b1},
        '{1'b1, 4'b1000, 1'b1, 8'd40, 4'b1101, 4'b0100, 1'b1},
        '{1'b1, 4'b0010, 1'b1, 8'd16, 4'b1111, 4'b0100, 1'b0},
        '{1'b1, 4'b1000, 1'b0, 8'd10, 4'b0111, 4'b0100, 1'b0},
        '{1'b1, 4'b0100, 1'b0, 8'd24, 4'b0011, 4'b0001, 1'b0},
        '{1'b1, 4'b1000, 1'b1, 8'd24, 4'b1011, 4'b0001, 1'b0},
        '{1'b1, 4'b0010, 1'b0, 8'd16, 4'b1001, 4'b0001, 1'b0},
        '{1'b1, 4'b0001, 1'b0, 8'd12, 4'b1000, 4'b1000, 1'b0},
        '{1'b1, 4'b1000, 1'b0, 8'd8,  4'b0000, 4'b0000, 1'b0},
        '{1'b0, 4'b0000, 1'b0, 8'd6,  4'b0000, 4'b0000, 1'b0}
    };

    string step_names [NUM_STEPS] = '{
        "single hart 2", "two harts", "three harts", "four harts rotate",
        "clear minor hart 3", "clear primary hart 2", "set minor hart 3",
        "clear minor hart 1", "clear primary hart 0", "clear last hart", "idle"
    };

    logic             clk = 1'b0;
    logic             rst;
    logic             set_hart;
    hstate_t          set_hstate;
    logic             set_hart_val;
    logic             imem_we;
    logic [AW-1:0]    imem_addr;
    instr_t           imem_data;
    hstate_t          issue_hstate;
    hstate_t          id_hstate;
    pc_t              id_pc;
    logic             is_load;
    logic             is_branch;
    hstate_t          acti_hstate;
    hstate_t          prim_hstate;

    // reference model registers
    hstate_t m_acti, m_prim, m_last;
    logic    m_imin, m_itwice;
    pc_t     m_pc [NUM_HARTS];
    hstate_t m_f_hstate, m_d_hstate;
    logic    m_f_valid, m_d_valid;
    pc_t     m_f_pc, m_d_pc;
    instr_t  m_f_instr, m_d_instr;
    instr_t  ref_mem [IMEM_DEPTH];

    // model values of the current cycle
    hstate_t c_issue, c_acti_n, c_prim_n, c_minor;
    logic    c_ld, c_br, c_hit;

    int          errors;
    int          fb_hits;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lfsr;

    always #2 clk = ~clk;

    hart_core_top #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .set_hart     (set_hart),
        .set_hstate   (set_hstate),
        .set_hart_val (set_hart_val),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .issue_hstate (issue_hstate),
        .id_hstate    (id_hstate),
        .id_pc        (id_pc),
        .is_load      (is_load),
        .is_branch    (is_branch),
        .acti_hstate  (acti_hstate),
        .prim_hstate  (prim_hstate)
    );

    function automatic hstate_t lowest_set(hstate_t m);
        hstate_t r;
        r = '0;
        for (int h = NUM_HARTS - 1; h >= 0; h--) begin
            if (m[h]) begin
                r = '0;
                r[h] = 1'b1;
            end
        end
        return r;
    endfunction

    // first set hart counting up from hart 0
    function automatic hidx_t lowest_index(hstate_t m);
        hidx_t idx;
        logic  found;
        idx = '0;
        found = 1'b0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (m[h] && !found) begin
                idx = hidx_t'(h);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    // shift right one hart and restart at the top hart when empty
    function automatic hstate_t shift_wrap(hstate_t m);
        hstate_t r;
        r = m >> 1;
        if (r == '0) r[NUM_HARTS-1] = 1'b1;
        return r;
    endfunction

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    // random class on top with an address pattern below
    task make_word(input logic [AW-1:0] addr, output instr_t w);
        logic b1;
        logic b0;
        take_bit(b1);
        take_bit(b0);
        w = {b1, b0, addr[5:0] ^ 6'h15, addr};
    endtask

    task check_hstate(input string name, input hstate_t got, input hstate_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h at %0t ns", name, got, exp, $time);
            errors++;
        end
    endtask

    task check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h at %0t ns", name, got, exp, $time);
            errors++;
        end
    endtask

    task check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h at %0t ns", name, got, exp, $time);
            errors++;
        end
    endtask

    task reset_model();
        m_acti = '0;
        m_prim = '0;
        m_last = '0;
        m_imin = 1'b0;
        m_itwice = 1'b0;
        for (int h = 0; h < NUM_HARTS; h++) m_pc[h] = '0;
        m_f_hstate = '0;
        m_f_valid = 1'b0;
        m_d_hstate = '0;
        m_d_valid = 1'b0;
        m_f_pc = 'x;
        m_d_pc = 'x;
        m_f_instr = 'x;
        m_d_instr = 'x;
    endtask

    // outputs settle by the falling edge
    task sample_and_check();
        hstate_t one_hot;
        logic    leave;
        @(negedge clk);
        c_acti_n = m_acti;
        if (set_hart) begin
            c_acti_n = set_hart_val ? (m_acti | set_hstate) : (m_acti & ~set_hstate);
        end
        leave = set_hart && !set_hart_val && ((set_hstate & m_prim) != '0);
        c_prim_n = (leave || (m_prim == '0)) ? lowest_set(c_acti_n) : m_prim;
        c_ld = m_d_valid && (op_class_t'(m_d_instr[15:14]) == OP_LOAD);
        c_br = m_d_valid && (op_class_t'(m_d_instr[15:14]) == OP_BRANCH);
        c_minor = m_acti & ~m_prim;
        one_hot = lowest_set(c_minor);
        c_hit = (m_d_hstate == m_prim) && (m_prim != '0);
        if (leave) c_issue = one_hot;
        else if (m_acti == '1) c_issue = shift_wrap(m_last);
        else if (c_minor == '0) c_issue = m_prim;
        else if ((c_ld || c_br) && c_hit) c_issue = one_hot;
        else if (m_imin) c_issue = m_itwice ? c_minor : (~m_last & c_minor);
        else c_issue = m_prim;
        if (c_hit && (c_ld || c_br)) fb_hits++;
        check_hstate("issue_hstate", issue_hstate, c_issue);
        check_hstate("acti_hstate", acti_hstate, m_acti);
        check_hstate("prim_hstate", prim_hstate, m_prim);
        check_hstate("id_hstate", id_hstate, m_d_hstate);
        check_flag("is_load", is_load, c_ld);
        check_flag("is_branch", is_branch, c_br);
        if (m_d_valid) check_pc("id_pc", id_pc, m_d_pc);
        check_hstate("issue outside acti", issue_hstate & ~acti_hstate, '0);
    endtask

    task advance_model();
        hidx_t rd;
        m_d_hstate = m_f_hstate;   // decode takes the old fetch stage
        m_d_valid = m_f_valid;
        m_d_pc = m_f_pc;
        m_d_instr = m_f_instr;
        rd = lowest_index(c_issue);
        m_f_hstate = c_issue;
        m_f_valid = (c_issue != '0);
        m_f_pc = m_pc[rd];
        m_f_instr = ref_mem[{rd, m_pc[rd][PC_BITS-1:0]}];
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (c_issue[h]) m_pc[h] = m_pc[h] + pc_t'(1);
        end
        if (imem_we) ref_mem[imem_addr] = imem_data;   // written after the read as in hardware
        m_imin = c_hit && (c_ld || (c_br && ($countones(m_acti) == 3)));
        m_itwice = c_ld && ($countones(c_minor) == 1);
        m_last = c_issue;
        m_acti = c_acti_n;
        m_prim = c_prim_n;
        @(posedge clk);
        #1;
    endtask

    task run_cycle();
        sample_and_check();
        advance_model();
    endtask

    task report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-22s ok", name);
        end else begin
            tests_failed++;
            $display("test %-22s FAILED, %0d errors", name, errors - errs_before);
        end
    endtask

    function automatic int table_cycles();
        int total;
        total = 0;
        for (int s = 0; s < NUM_STEPS; s++) total += int'(STEPS[s].cycles);
        return total;
    endfunction

    initial begin : watchdog
        int limit;
        limit = (table_cycles() + IMEM_DEPTH + RESET_CYCLES + 1) * 4 + 400;
        #(limit);
        $display("timeout: run did not finish within %0d ns", limit);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        int     step_errs;
        int     fb_start;
        instr_t word;
        rst = 1'b1;
        set_hart = 1'b0;
        set_hstate = '0;
        set_hart_val = 1'b0;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        errors = 0;
        fb_hits = 0;
        tests_run = 0;
        tests_failed = 0;
        lfsr = 32'hacc7_b54f;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_model();

        step_errs = errors;
        sample_and_check();
        check_hstate("issue_hstate", issue_hstate, '0);   // plain zero after reset
        check_hstate("acti_hstate", acti_hstate, '0);
        check_hstate("prim_hstate", prim_hstate, '0);
        check_flag("is_load", is_load, 1'b0);
        check_flag("is_branch", is_branch, 1'b0);
        advance_model();
        report_test("reset", step_errs);

        step_errs = errors;
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            make_word(AW'(a), word);
            imem_we = 1'b1;
            imem_addr = AW'(a);
            imem_data = word;
            run_cycle();
        end
        imem_we = 1'b0;
        report_test("imem preload", step_errs);

        for (int s = 0; s < NUM_STEPS; s++) begin
            step_errs = errors;
            fb_start = fb_hits;
            set_hart = STEPS[s].do_set;
            set_hstate = STEPS[s].hstate;
            set_hart_val = STEPS[s].val;
            run_cycle();
            set_hart = 1'b0;   // command lasts one cycle
            for (int c = 1; c < int'(STEPS[s].cycles); c++) run_cycle();
            check_hstate("acti_hstate", acti_hstate, STEPS[s].exp_acti);
            check_hstate("prim_hstate", prim_hstate, STEPS[s].exp_prim);
            if (STEPS[s].need_fb && (fb_hits == fb_start)) begin
                $display("no load or branch of the primary hart reached decode in step %0d", s);
                errors++;
            end
            report_test(step_names[s], step_errs);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: files.f
hart_pkg.sv
hart_stage_if.sv
hart_state_unit.sv
hart_switch.sv
hart_fetch.sv
hart_decode.sv
hart_core_top.sv
tb_hart_core.sv

// File: Makefile
TB  = tb_hart_core
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module hart_core_top -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TB) -f files.f -o $(TB)
	./obj_dir/$(TB) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
